//--- hw/astar_cfg.svh
`ifndef ASTAR_CFG_SVH
`define ASTAR_CFG_SVH

//////////////////////////////
// sizes
//////////////////////////////

`define ASTAR_COORD_W    8   // one grid coordinate
`define ASTAR_LIST_DEPTH 16  // open list entries
`define ASTAR_IDX_W      5   // index or count, holds 0..16
`define ASTAR_COST_W     16  // octile cost

//////////////////////////////
// wishbone address map
//////////////////////////////

`define ASTAR_WB_ADR_W   6   // word address
`define ASTAR_WB_DAT_W   16

// entry n at base + n, x in low byte, y in high byte
`define ASTAR_LIST_BASE  6'h20

`endif

//--- hw/astar_pkg.sv
`include "astar_cfg.svh"

package astar_pkg;

	typedef logic [`ASTAR_COORD_W-1:0] coord_t;

	// y first so that x lands in the low byte
	typedef struct packed {
		coord_t y;
		coord_t x;
	} node_t;

	typedef logic [`ASTAR_IDX_W-1:0] idx_t;    // list index or node count
	typedef logic [`ASTAR_COST_W-1:0] cost_t;  // scaled by 10 per straight step

	// sorter FSM
	typedef enum logic [1:0] {
		SORT_IDLE,
		SORT_SCAN,  // compare one pair
		SORT_SWAP,  // exchange that pair
		SORT_DONE
	} sort_state_e;

	// register addresses below the list window
	typedef enum logic [`ASTAR_WB_ADR_W-1:0] {
		REG_CTRL   = 6'h00,  // bit 0 write starts a sort
		REG_STATUS = 6'h01,  // bit 0 busy, bit 1 done
		REG_GOAL   = 6'h02,  // goal x low byte, goal y high byte
		REG_COUNT  = 6'h03   // number of nodes, max 16
	} reg_addr_e;

endpackage

//--- hw/astar_sort_ifs.sv
`timescale 1ns/1ps
`include "astar_cfg.svh"

// sorter view of the list, a neighbouring pair at a time
interface open_list_if;
	astar_pkg::idx_t pair_idx;   // left entry of the pair
	logic swap;                  // exchange the pair at this edge
	astar_pkg::node_t node_a;    // entry at pair_idx
	astar_pkg::node_t node_b;    // entry at pair_idx + 1

	modport sorter (output pair_idx, output swap, input node_a, input node_b);
	modport list (input pair_idx, input swap, output node_a, output node_b);
endinterface

// bus view of the list, one word at a time
interface list_bus_if;
	logic [$clog2(`ASTAR_LIST_DEPTH)-1:0] addr;
	logic we;
	astar_pkg::node_t wdata;
	astar_pkg::node_t rdata;     // combinational read

	modport host (output addr, output we, output wdata, input rdata);
	modport list (input addr, input we, input wdata, output rdata);
endinterface

//--- hw/open_list_ram.sv
`timescale 1ns/1ps
`include "astar_cfg.svh"

module open_list_ram (
	input logic Clk,
	open_list_if.list sort,
	list_bus_if.list bus
);

	localparam int AW = $clog2(`ASTAR_LIST_DEPTH);

	astar_pkg::node_t mem [`ASTAR_LIST_DEPTH];

	logic [AW-1:0] idx_a;
	logic [AW-1:0] idx_b;

	// the sorter never points past depth - 2, so the wrap is harmless
	assign idx_a = sort.pair_idx[AW-1:0];
	assign idx_b = idx_a + 1'b1;

	//////////////////////////////
	// read ports
	//////////////////////////////

	assign sort.node_a = mem[idx_a];
	assign sort.node_b = mem[idx_b];
	assign bus.rdata = mem[bus.addr];

	//////////////////////////////
	// write ports
	//////////////////////////////

	// bus writes are held off while the sorter runs, so the two never collide
	always_ff @(posedge Clk)
	begin
		if (sort.swap)
		begin
			mem[idx_a] <= mem[idx_b];  // exchange in one edge
			mem[idx_b] <= mem[idx_a];
		end
		else if (bus.we)
		begin
			mem[bus.addr] <= bus.wdata;
		end
	end

endmodule

//--- hw/octile_heuristic.sv
`timescale 1ns/1ps

module octile_heuristic (
	input astar_pkg::node_t node,
	input astar_pkg::node_t goal,
	output astar_pkg::cost_t cost
);

	astar_pkg::coord_t dx;
	astar_pkg::coord_t dy;
	astar_pkg::coord_t d_min;
	astar_pkg::coord_t d_max;
	astar_pkg::coord_t d_straight;
	astar_pkg::cost_t diag_cost;
	astar_pkg::cost_t straight_cost;

	// absolute distances on each axis
	assign dx = (node.x > goal.x) ? node.x - goal.x : goal.x - node.x;
	assign dy = (node.y > goal.y) ? node.y - goal.y : goal.y - node.y;

	assign d_min = (dx < dy) ? dx : dy;
	assign d_max = (dx < dy) ? dy : dx;
	assign d_straight = d_max - d_min;  // steps left after the diagonal run

	// 14 per diagonal step, 10 per straight step
	assign diag_cost = astar_pkg::cost_t'(d_min) * astar_pkg::cost_t'(14);
	assign straight_cost = astar_pkg::cost_t'(d_straight) * astar_pkg::cost_t'(10);

	// worst case 14 * 255 still fits in 16 bits
	assign cost = diag_cost + straight_cost;

endmodule

//--- hw/bubble_sorter.sv
`timescale 1ns/1ps

module bubble_sorter (
	input logic Clk,
	input logic Reset,
	input logic start,
	input astar_pkg::node_t goal,
	input astar_pkg::idx_t count,
	output logic busy,
	output logic done,
	open_list_if.sorter list
);

	astar_pkg::sort_state_e state;
	astar_pkg::idx_t pair_idx;
	logic swapped;          // a swap happened in this pass
	logic done_q;

	astar_pkg::cost_t cost_a;
	astar_pkg::cost_t cost_b;
	logic last_pair;
	logic do_swap;

	//////////////////////////////
	// pair costs
	//////////////////////////////

	octile_heuristic u_cost_a (
		.node (list.node_a),
		.goal (goal),
		.cost (cost_a)
	);

	octile_heuristic u_cost_b (
		.node (list.node_b),
		.goal (goal),
		.cost (cost_b)
	);

	// >= keeps the pass bounded even for a count below 2
	assign last_pair = (pair_idx + astar_pkg::idx_t'(2)) >= count;

	// strictly cheaper only, equal costs keep their order
	assign do_swap = (count >= astar_pkg::idx_t'(2)) && (cost_b < cost_a);

	assign list.pair_idx = pair_idx;
	assign list.swap = (state == astar_pkg::SORT_SWAP);

	assign busy = (state == astar_pkg::SORT_SCAN) || (state == astar_pkg::SORT_SWAP);
	assign done = done_q;

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= astar_pkg::SORT_IDLE;
			pair_idx <= '0;
			swapped <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			case (state)
				astar_pkg::SORT_IDLE, astar_pkg::SORT_DONE:
				begin
					if (start)
					begin
						state <= astar_pkg::SORT_SCAN;
						pair_idx <= '0;
						swapped <= 1'b0;
						done_q <= 1'b0;  // a new sort clears the old result
					end
				end
				astar_pkg::SORT_SCAN:
				begin
					if (do_swap)
						state <= astar_pkg::SORT_SWAP;  // pair stays put one more cycle
					else if (!last_pair)
						pair_idx <= pair_idx + 1'b1;
					else if (swapped)
					begin
						pair_idx <= '0;  // dirty pass, go again
						swapped <= 1'b0;
					end
					else
					begin
						state <= astar_pkg::SORT_DONE;  // clean pass
						done_q <= 1'b1;
					end
				end
				astar_pkg::SORT_SWAP:
				begin
					state <= astar_pkg::SORT_SCAN;
					if (last_pair)
					begin
						pair_idx <= '0;  // this pass swapped, so another one follows
						swapped <= 1'b0;
					end
					else
					begin
						pair_idx <= pair_idx + 1'b1;
						swapped <= 1'b1;
					end
				end
				default:
					state <= astar_pkg::SORT_IDLE;
			endcase
		end
	end

endmodule

//--- hw/wb_sort_regs.sv
`timescale 1ns/1ps
`include "astar_cfg.svh"

module wb_sort_regs (
	input logic Clk,
	input logic Reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`ASTAR_WB_ADR_W-1:0] wb_adr,
	input logic [`ASTAR_WB_DAT_W-1:0] wb_dat_w,
	output logic [`ASTAR_WB_DAT_W-1:0] wb_dat_r,
	output logic wb_ack,
	list_bus_if.host bus,
	output logic start,
	output astar_pkg::node_t goal,
	output astar_pkg::idx_t count,
	input logic busy,
	input logic done
);

	localparam int AW = $clog2(`ASTAR_LIST_DEPTH);
	localparam astar_pkg::idx_t MAX_COUNT = `ASTAR_LIST_DEPTH;

	logic access;      // new cycle, ack not yet given
	logic wr_access;
	logic [`ASTAR_WB_ADR_W-1:0] list_off;
	logic in_list;
	logic [`ASTAR_WB_DAT_W-1:0] rd_data;

	assign access = wb_cyc & wb_stb & ~wb_ack;
	assign wr_access = access & wb_we;

	// addresses below the base wrap to large offsets and miss the window
	assign list_off = wb_adr - `ASTAR_LIST_BASE;
	assign in_list = list_off < `ASTAR_LIST_DEPTH;

	//////////////////////////////
	// list path
	//////////////////////////////

	assign bus.addr = list_off[AW-1:0];
	assign bus.wdata = wb_dat_w;
	assign bus.we = wr_access & in_list & ~busy;  // dropped, still acked, while busy

	// one cycle wide since ack follows on the next edge
	assign start = wr_access & (wb_adr == astar_pkg::REG_CTRL) & wb_dat_w[0] & ~busy;

	always_comb
	begin
		rd_data = '0;  // unmapped reads return zero
		if (in_list)
			rd_data = bus.rdata;
		else
		begin
			case (wb_adr)
				astar_pkg::REG_STATUS: rd_data[1:0] = {done, busy};
				astar_pkg::REG_GOAL: rd_data = goal;
				astar_pkg::REG_COUNT: rd_data[`ASTAR_IDX_W-1:0] = count;
				default: rd_data = '0;
			endcase
		end
	end

	//////////////////////////////
	// ack and registers
	//////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;  // single cycle even if stb stays high
	end

	always_ff @(posedge Clk)
	begin
		if (access & ~wb_we)
			wb_dat_r <= rd_data;
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			goal <= '0;
			count <= '0;
		end
		else if (wr_access)
		begin
			case (wb_adr)
				astar_pkg::REG_GOAL: goal <= wb_dat_w;
				astar_pkg::REG_COUNT:
				begin
					if (wb_dat_w > `ASTAR_LIST_DEPTH)
						count <= MAX_COUNT;  // saturate at list depth
					else
						count <= wb_dat_w[`ASTAR_IDX_W-1:0];
				end
				default: ;
			endcase
		end
	end

endmodule

//--- hw/astar_sort_top.sv
`timescale 1ns/1ps
`include "astar_cfg.svh"

module astar_sort_top (
	input logic Clk,
	input logic Reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`ASTAR_WB_ADR_W-1:0] wb_adr,
	input logic [`ASTAR_WB_DAT_W-1:0] wb_dat_w,
	output logic [`ASTAR_WB_DAT_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic done
);

	logic start;
	logic busy;
	astar_pkg::node_t goal;
	astar_pkg::idx_t count;

	open_list_if sort_if ();
	list_bus_if bus_if ();

	// host side, registers and list window
	wb_sort_regs u_regs (
		.Clk      (Clk),
		.Reset    (Reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.bus      (bus_if.host),
		.start    (start),
		.goal     (goal),
		.count    (count),
		.busy     (busy),
		.done     (done)
	);

	bubble_sorter u_sorter (
		.Clk   (Clk),
		.Reset (Reset),
		.start (start),
		.goal  (goal),
		.count (count),
		.busy  (busy),
		.done  (done),
		.list  (sort_if.sorter)
	);

	open_list_ram u_list (
		.Clk  (Clk),
		.sort (sort_if.list),
		.bus  (bus_if.list)
	);

endmodule

//--- tb/astar_sort_props.sv
`timescale 1ns/1ps

module astar_sort_props (
	input logic Clk,
	input logic Reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic busy,
	input logic done,
	input logic swap,
	input logic bus_we
);

	int failures = 0;  // failed assertions so far

	//////////////////////////////
	// wishbone handshake
	//////////////////////////////

	// ack answers a strobe seen one edge earlier
	ack_after_stb: assert property (@(posedge Clk) disable iff (Reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
	else
	begin
		failures++;
		$error("wb_ack high without cyc and stb in the cycle before");
	end

	ack_one_cycle: assert property (@(posedge Clk) disable iff (Reset)
		wb_ack |=> !wb_ack)
	else
	begin
		failures++;
		$error("wb_ack held high for two cycles");
	end

	//////////////////////////////
	// sorter
	//////////////////////////////

	// the bus side must hold its list writes off while the pair is exchanged
	swap_in_busy: assert property (@(posedge Clk) disable iff (Reset)
		swap |-> (busy && !bus_we))
	else
	begin
		failures++;
		$error("list swap while not busy or together with a bus write");
	end

	busy_xor_done: assert property (@(posedge Clk) disable iff (Reset)
		!(busy && done))
	else
	begin
		failures++;
		$error("busy and done high together");
	end

endmodule

bind astar_sort_top astar_sort_props u_props (
	.Clk    (Clk),
	.Reset  (Reset),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.busy   (busy),
	.done   (done),
	.swap   (sort_if.swap),  // only visible inside the interface
	.bus_we (bus_if.we)
);

//--- tb/tb_astar_sort.sv
`timescale 1ns/1ps
`include "astar_cfg.svh"

module tb_astar_sort;

	localparam int DEPTH = `ASTAR_LIST_DEPTH;
	localparam int ACK_LIMIT = 16;     // cycles per bus access
	localparam int POLL_LIMIT = 1000;  // status reads per sort

	logic Clk;
	logic Reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`ASTAR_WB_ADR_W-1:0] wb_adr;
	logic [`ASTAR_WB_DAT_W-1:0] wb_dat_w;
	logic [`ASTAR_WB_DAT_W-1:0] wb_dat_r;
	logic wb_ack;
	logic done;

	astar_pkg::node_t shadow [DEPTH];    // list as the host wrote it
	astar_pkg::node_t expected [DEPTH];  // model result
	logic [31:0] lcg_state;
	int checks;
	int errors;
	int test_errors;                     // error count when the test began
	time start_time;                     // negedge after the start edge
	time done_time;                      // last rising edge of done

	astar_sort_top uut (
		.Clk      (Clk),
		.Reset    (Reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.done     (done)
	);

	always #5 Clk = ~Clk;

	always @(posedge done)
		done_time = $time;

	//////////////////////////////
	// model and helpers
	//////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// 14 per diagonal step, 10 per straight step
	function automatic int octile_cost(input astar_pkg::node_t n, input astar_pkg::node_t g);
		int dx;
		int dy;
		dx = int'(n.x) - int'(g.x);
		dy = int'(n.y) - int'(g.y);
		if (dx < 0)
			dx = -dx;
		if (dy < 0)
			dy = -dy;
		if (dx < dy)
			return 14 * dx + 10 * (dy - dx);
		return 14 * dy + 10 * (dx - dy);
	endfunction

	// insertion sort, a node only moves past strictly dearer ones
	task automatic model_sort(input int n, input astar_pkg::node_t g);
		astar_pkg::node_t key;
		int i;
		int j;
		expected = shadow;
		for (i = 1; i < n; i++)
		begin
			key = expected[i];
			j = i - 1;
			while (j >= 0 && octile_cost(expected[j], g) > octile_cost(key, g))
			begin
				expected[j + 1] = expected[j];
				j--;
			end
			expected[j + 1] = key;
		end
	endtask

	// busy cycles of a sort, one per scanned pair plus one per swap
	function automatic int sort_cycles(input int n, input astar_pkg::node_t g);
		astar_pkg::node_t a [DEPTH];
		astar_pkg::node_t t;
		int cycles;
		logic dirty;
		a = shadow;
		cycles = 0;
		if (n < 2)
			return 1;
		do
		begin
			dirty = 1'b0;
			for (int i = 0; i < n - 1; i++)
			begin
				cycles++;
				if (octile_cost(a[i + 1], g) < octile_cost(a[i], g))
				begin
					t = a[i];
					a[i] = a[i + 1];
					a[i + 1] = t;
					cycles++;
					dirty = 1'b1;
				end
			end
		end
		while (dirty);
		return cycles;
	endfunction

	task automatic fill_shadow();
		for (int i = 0; i < DEPTH; i++)
			shadow[i] = 16'h5a3c ^ (16'(i) * 16'h0907);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$finish;
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_node(input string name, input astar_pkg::node_t got,
		input astar_pkg::node_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_idx(input string name, input astar_pkg::idx_t got,
		input astar_pkg::idx_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// {done, busy}
	task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic mark_test();
		test_errors = errors;
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors)
			$display("%s: pass", name);
		else
			$display("%s: %0d mismatches", name, errors - test_errors);
	endtask

	//////////////////////////////
	// bus tasks
	//////////////////////////////

	// drive on the falling edge, look for ack on the next falling edges
	task automatic wb_access(input logic we, input logic [`ASTAR_WB_ADR_W-1:0] adr,
		input logic [15:0] wdata, output logic [15:0] rdata);
		int n;
		@(negedge Clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		n = 0;
		do
		begin
			@(negedge Clk);
			n++;
		end
		while (!wb_ack && n < ACK_LIMIT);
		if (!wb_ack)
			abort_run($sformatf("no wishbone ack for address %h", adr));
		else
		begin
			rdata = wb_dat_r;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
		end
	endtask

	task automatic wb_write(input logic [`ASTAR_WB_ADR_W-1:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [`ASTAR_WB_ADR_W-1:0] adr, output logic [15:0] data);
		wb_access(1'b0, adr, 16'h0000, data);
	endtask

	task automatic wait_done();
		logic [15:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[1] && polls < POLL_LIMIT)
		begin
			wb_read(astar_pkg::REG_STATUS, status);
			polls++;
		end
		if (!status[1])
			abort_run("sorter never reported done");
		else
		begin
			check_status("status at done", status[1:0], 2'b10);
			check_status("done output", {done, status[0]}, 2'b10);
		end
	endtask

	task automatic load_list();
		for (int i = 0; i < DEPTH; i++)
			wb_write(6'(`ASTAR_LIST_BASE + i), shadow[i]);
	endtask

	task automatic run_sort(input int n, input astar_pkg::node_t g);
		wb_write(astar_pkg::REG_GOAL, g);
		wb_write(astar_pkg::REG_COUNT, 16'(n));
		wb_write(astar_pkg::REG_CTRL, 16'h0001);
		wait_done();
	endtask

	task automatic check_list(input string tag);
		logic [15:0] d;
		for (int i = 0; i < DEPTH; i++)
		begin
			wb_read(6'(`ASTAR_LIST_BASE + i), d);
			check_node($sformatf("%s list[%0d]", tag, i), d, expected[i]);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_registers();
		logic [15:0] d;
		mark_test();
		wb_read(astar_pkg::REG_STATUS, d);
		check_status("status after reset", d[1:0], 2'b00);
		check_status("done after reset", {done, 1'b0}, 2'b00);
		wb_read(astar_pkg::REG_GOAL, d);
		check_node("goal after reset", d, 16'h0000);
		wb_read(astar_pkg::REG_COUNT, d);
		check_idx("count after reset", d[`ASTAR_IDX_W-1:0], 5'd0);
		wb_write(astar_pkg::REG_GOAL, 16'h3a17);
		wb_read(astar_pkg::REG_GOAL, d);
		check_node("goal", d, 16'h3a17);
		wb_write(astar_pkg::REG_COUNT, 16'd9);
		wb_read(astar_pkg::REG_COUNT, d);
		check_idx("count", d[`ASTAR_IDX_W-1:0], 5'd9);
		wb_write(astar_pkg::REG_COUNT, 16'd40);  // saturates
		wb_read(astar_pkg::REG_COUNT, d);
		check_idx("count saturated", d[`ASTAR_IDX_W-1:0], 5'd16);
		report_test("registers");
	endtask

	task automatic test_directed_sort();
		astar_pkg::node_t g;
		mark_test();
		fill_shadow();
		g = '{x: 8'd10, y: 8'd10};
		shadow[0] = '{x: 8'd0, y: 8'd0};    // 140
		shadow[1] = '{x: 8'd10, y: 8'd14};  // 40
		shadow[2] = '{x: 8'd20, y: 8'd3};   // 128
		shadow[3] = '{x: 8'd14, y: 8'd10};  // 40, ties with [1]
		shadow[4] = '{x: 8'd13, y: 8'd13};  // 42
		shadow[5] = '{x: 8'd11, y: 8'd11};  // 14
		shadow[6] = '{x: 8'd6, y: 8'd10};   // 40 again
		shadow[7] = '{x: 8'd10, y: 8'd10};  // on the goal
		load_list();
		model_sort(8, g);
		run_sort(8, g);
		check_list("directed");
		report_test("directed sort");
	endtask

	task automatic test_random_sorts();
		astar_pkg::node_t g;
		logic [31:0] r;
		int n;
		mark_test();
		for (int t = 0; t < 5; t++)
		begin
			fill_shadow();
			r = lcg_next();
			n = 2 + int'(r[19:16]) % 15;
			r = lcg_next();
			g = r[23:8];
			for (int i = 0; i < n; i++)
			begin
				r = lcg_next();
				shadow[i] = r[23:8];
			end
			load_list();
			model_sort(n, g);
			run_sort(n, g);
			check_list($sformatf("random %0d", t));
		end
		report_test("random sorts");
	endtask

	task automatic test_busy_guards();
		astar_pkg::node_t g;
		logic [15:0] d;
		int cycles;
		mark_test();
		g = '{x: 8'd0, y: 8'd0};
		for (int i = 0; i < DEPTH; i++)
			shadow[i] = '{x: 8'(15 - i), y: 8'(15 - i)};  // worst case order
		load_list();
		model_sort(DEPTH, g);
		wb_write(astar_pkg::REG_GOAL, g);
		wb_write(astar_pkg::REG_COUNT, 16'(DEPTH));
		wb_write(astar_pkg::REG_CTRL, 16'h0001);
		start_time = $time;
		wb_read(astar_pkg::REG_STATUS, d);
		check_status("status while sorting", d[1:0], 2'b01);
		wb_write(`ASTAR_LIST_BASE, 16'hffff);   // must be dropped
		wb_write(astar_pkg::REG_CTRL, 16'h0001);  // must be ignored
		wait_done();
		// start_time lies half a period after the start edge
		cycles = int'((done_time - start_time + 5) / 10);
		check_cycles("sort cycles", cycles, sort_cycles(DEPTH, g));
		check_list("busy");
		report_test("busy guards");
	endtask

	task automatic test_short_and_sorted();
		astar_pkg::node_t g;
		mark_test();
		shadow = expected;  // list is sorted for goal 0,0 now
		g = '{x: 8'd200, y: 8'd3};
		for (int n = 0; n < 2; n++)
		begin
			model_sort(n, g);
			run_sort(n, g);
			check_list($sformatf("count %0d", n));
		end
		g = '{x: 8'd0, y: 8'd0};
		model_sort(DEPTH, g);
		run_sort(DEPTH, g);
		check_list("presorted");
		report_test("short and sorted lists");
	endtask

	initial
	begin
		Clk = 1'b0;
		Reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		lcg_state = 32'h79bc;
		checks = 0;
		errors = 0;
		test_errors = 0;
		start_time = 0;
		done_time = 0;
		repeat (2) @(posedge Clk);
		@(negedge Clk);
		Reset = 1'b0;

		test_registers();
		test_directed_sort();
		test_random_sorts();
		test_busy_guards();
		test_short_and_sorted();

		errors += uut.u_props.failures;  // assertion failures of the bound checker
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hw
hw/astar_pkg.sv
hw/astar_sort_ifs.sv
hw/open_list_ram.sv
hw/octile_heuristic.sv
hw/bubble_sorter.sv
hw/wb_sort_regs.sv
hw/astar_sort_top.sv
tb/astar_sort_props.sv
tb/tb_astar_sort.sv

//--- Bender.yml
package:
  name: astar_sort

sources:
  # design
  - include_dirs:
      - hw
    files:
      - hw/astar_pkg.sv
      - hw/astar_sort_ifs.sv
      - hw/open_list_ram.sv
      - hw/octile_heuristic.sv
      - hw/bubble_sorter.sv
      - hw/wb_sort_regs.sv
      - hw/astar_sort_top.sv
  # simulation only
  - target: test
    include_dirs:
      - hw
    files:
      - tb/astar_sort_props.sv
      - tb/tb_astar_sort.sv
